// ==== verilog/gb_defs.svh ====
`ifndef GB_DEFS_SVH
`define GB_DEFS_SVH

// ------------------------------------------------------------
// io register addresses
// ------------------------------------------------------------
`define GB_ADDR_P1   16'hFF00   // joypad select / matrix
`define GB_ADDR_SB   16'hFF01   // serial data, no real shifter behind it
`define GB_ADDR_SC   16'hFF02   // serial control
`define GB_ADDR_IF   16'hFF0F   // interrupt flags
`define GB_ADDR_BOOT 16'hFF50   // boot rom disable
`define GB_ADDR_IE   16'hFFFF   // interrupt enable

// memory address widths
`define GB_BOOT_AW 8    // 256 byte boot rom
`define GB_WRAM_AW 13   // 8k work ram
`define GB_ZP_AW   7    // 128 entries, top one shadowed by IE

// interrupt vectors
`define GB_IRQ_VEC_BASE 8'h40
`define GB_IRQ_VEC_STEP 8'h08
`define GB_IRQ_VEC_NONE 8'h55   // ack with nothing pending

// value seen at FF50 by the boot code when fast boot is wanted
`define GB_FAST_BOOT_FLAG 8'h42

// dummy serial transfer, 8192 Hz bit clock
`define GB_SER_BIT_CYCLES 512
`define GB_SER_BITS       8

`define GB_OPEN_BUS 8'hFF   // undecoded reads

`endif

// ==== verilog/gb_pkg.sv ====
`default_nettype none

package gb_pkg;

	typedef logic [15:0] addr_t;   // cpu / cart address
	typedef logic [7:0]  data_t;   // bus byte
	typedef logic [4:0]  irq_t;    // vblank, lcd, timer, serial, joypad
	typedef logic [7:0]  joy_t;    // right left up down a b select start

	// who drives rd_data in the cycle after a read or ack
	typedef enum logic [1:0] {
		RD_BYTE,   // registered small-register / rom / cart byte
		RD_WRAM,
		RD_ZP,
		RD_VEC     // interrupt vector
	} rd_src_t;

	typedef enum logic {SER_IDLE, SER_SHIFT} ser_state_t;

endpackage

`default_nettype wire

// ==== verilog/spram.sv ====
`timescale 1ns/1ps
`default_nettype none

module spram #(
	parameter int addr_width = 13
) (
	input  wire                    clk_cpu,
	input  wire [addr_width-1:0]   address,
	input  wire                    we,
	input  gb_pkg::data_t          data,
	output gb_pkg::data_t          q
);

	gb_pkg::data_t mem [0:(1 << addr_width)-1];

	// write first into the array, read is registered (old data on collision)
	always_ff @(posedge clk_cpu) begin
		if (we)
			mem[address] <= data;
		q <= mem[address];
	end

endmodule

`default_nettype wire

// ==== verilog/boot_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gb_defs.svh"

module boot_rom (
	input  wire                     clk_cpu,
	input  wire                     reset,
	input  wire [`GB_BOOT_AW-1:0]   addr,       // byte within the boot window
	input  wire                     boot_wr,
	input  gb_pkg::data_t           wr_data,
	output logic                    boot_en,
	output gb_pkg::data_t           boot_data
);

	gb_pkg::data_t rom [0:(1 << `GB_BOOT_AW)-1];

	initial begin
		$readmemh("verilog/boot_rom.hex", rom);
	end

	assign boot_data = rom[addr];   // async, mem_map registers it

	// once unmapped the rom stays gone until reset
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			boot_en <= 1'b1;
		end else if (boot_wr && wr_data[0]) begin
			boot_en <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/irq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gb_defs.svh"

module irq_ctrl (
	input  wire            clk_cpu,
	input  wire            reset,
	input  gb_pkg::irq_t   irq_src,   // one-cycle event pulses
	input  wire            ie_wr,
	input  wire            if_wr,
	input  gb_pkg::data_t  wr_data,
	input  wire            irq_ack,
	output gb_pkg::irq_t   ie_val,
	output gb_pkg::irq_t   if_val,
	output gb_pkg::data_t  irq_vec,
	output logic           irq_n
);

	gb_pkg::irq_t  ie_r, if_r;
	gb_pkg::irq_t  pend, win, clr;
	logic [2:0]    win_idx;
	gb_pkg::data_t vec_next;

	assign ie_val = ie_r;
	assign if_val = if_r;
	assign pend   = ie_r & if_r;
	assign irq_n  = ~|pend;   // low while anything enabled is pending

	// ------------------------------------------------------------
	// fixed priority, bit 0 (vblank) wins
	// ------------------------------------------------------------
	always_comb begin
		win_idx = 3'd0;
		for (int i = 4; i >= 0; i--) begin
			if (pend[i])
				win_idx = 3'(i);   // last hit is the lowest index
		end
		win = (|pend) ? gb_pkg::irq_t'(5'b00001 << win_idx) : '0;
		if (|pend)
			vec_next = `GB_IRQ_VEC_BASE + `GB_IRQ_VEC_STEP * gb_pkg::data_t'(win_idx);
		else
			vec_next = `GB_IRQ_VEC_NONE;
	end

	assign clr = irq_ack ? win : '0;

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			ie_r <= '0;
			if_r <= '0;
		end else begin
			if (ie_wr)
				ie_r <= wr_data[4:0];
			if (if_wr)
				if_r <= wr_data[4:0];   // cpu write beats events
			else
				if_r <= (if_r & ~clr) | irq_src;   // new event survives an ack
		end
	end

	// vector for the ack data cycle
	always_ff @(posedge clk_cpu) begin
		if (irq_ack)
			irq_vec <= vec_next;
	end

endmodule

`default_nettype wire

// ==== verilog/joypad.sv ====
`timescale 1ns/1ps
`default_nettype none

module joypad (
	input  wire            clk_cpu,
	input  wire            reset,
	input  gb_pkg::joy_t   joystick,   // active high buttons, async
	input  wire            joy_wr,
	input  gb_pkg::data_t  wr_data,
	output gb_pkg::data_t  joy_val,
	output logic           joy_irq
);

	logic [1:0]   sel;           // P14 / P15, 0 = group enabled
	gb_pkg::joy_t sync1, sync2;  // two-flop synchronizer
	gb_pkg::joy_t press, press_d;

	// pressed lines of the enabled groups, directions low nibble
	assign press = sync2 & {{4{~sel[1]}}, {4{~sel[0]}}};

	// matrix lines read low when any enabled button on them is held
	assign joy_val = {2'b11, sel, ~(press[3:0] | press[7:4])};

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sel     <= 2'b00;
			sync1   <= '0;
			sync2   <= '0;
			press_d <= '0;
			joy_irq <= 1'b0;
		end else begin
			if (joy_wr)
				sel <= wr_data[5:4];
			sync1   <= joystick;
			sync2   <= sync1;
			press_d <= press;
			joy_irq <= |(press & ~press_d);   // new press edge, one cycle
		end
	end

endmodule

`default_nettype wire

// ==== verilog/serial_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gb_defs.svh"

module serial_port (
	input  wire            clk_cpu,
	input  wire            reset,
	input  wire            sc_wr,
	input  gb_pkg::data_t  wr_data,
	output gb_pkg::data_t  sc_val,
	output logic           ser_irq
);

	localparam int DIV_W = $clog2(`GB_SER_BIT_CYCLES);
	localparam int CNT_W = $clog2(`GB_SER_BITS);

	gb_pkg::ser_state_t state;
	logic               sc_start, sc_clk;
	logic [DIV_W-1:0]   div;      // cycles left in this bit
	logic [CNT_W-1:0]   bit_cnt;  // bits left after this one

	assign sc_val = {sc_start, 6'h3F, sc_clk};

	// ------------------------------------------------------------
	// transfer timer, no data actually shifts
	// ------------------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			state    <= gb_pkg::SER_IDLE;
			sc_start <= 1'b0;
			sc_clk   <= 1'b0;
			div      <= '0;
			bit_cnt  <= '0;
			ser_irq  <= 1'b0;
		end else begin
			ser_irq <= 1'b0;
			if (sc_wr) begin
				sc_start <= wr_data[7];
				sc_clk   <= wr_data[0];
				div      <= DIV_W'(`GB_SER_BIT_CYCLES - 1);
				bit_cnt  <= CNT_W'(`GB_SER_BITS - 1);
				// external clock never arrives, so only internal clock runs
				if (wr_data[7] && wr_data[0])
					state <= gb_pkg::SER_SHIFT;
				else
					state <= gb_pkg::SER_IDLE;
			end else begin
				case (state)
					gb_pkg::SER_SHIFT: begin
						div <= div - 1'b1;
						if (div == '0) begin
							div <= DIV_W'(`GB_SER_BIT_CYCLES - 1);
							if (bit_cnt == '0) begin   // last bit done
								ser_irq  <= 1'b1;
								sc_start <= 1'b0;
								state    <= gb_pkg::SER_IDLE;
							end else begin
								bit_cnt <= bit_cnt - 1'b1;
							end
						end
					end
					default: ;   // idle, hold
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mem_map.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gb_defs.svh"

module mem_map (
	input  wire            clk_cpu,
	input  wire            reset,
	input  gb_pkg::addr_t  addr,
	input  gb_pkg::data_t  wr_data,
	input  wire            rd,
	input  wire            wr,
	input  wire            irq_ack,
	input  wire            fast_boot,
	input  gb_pkg::data_t  cart_do,
	input  wire            boot_en,
	input  gb_pkg::data_t  boot_data,
	input  gb_pkg::data_t  wram_q,
	input  gb_pkg::data_t  zp_q,
	input  gb_pkg::irq_t   ie_val,
	input  gb_pkg::irq_t   if_val,
	input  gb_pkg::data_t  irq_vec,
	input  gb_pkg::data_t  joy_val,
	input  gb_pkg::data_t  sc_val,
	output gb_pkg::data_t  rd_data,
	output gb_pkg::addr_t  cart_addr,
	output gb_pkg::data_t  cart_di,
	output logic           cart_rd,
	output logic           cart_wr,
	output logic           wram_we,
	output logic           zp_we,
	output logic           ie_wr,
	output logic           if_wr,
	output logic           joy_wr,
	output logic           sc_wr,
	output logic           boot_wr
);

	// ------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------
	logic sel_boot, sel_cart, sel_wram, sel_zp;
	logic sel_p1, sel_if, sel_sc, sel_ie, sel_fast, sel_bootreg;

	assign sel_boot = boot_en && (addr[15:8] == 8'h00);   // 0000-00FF overlay
	assign sel_cart = (!addr[15] && !sel_boot)            // rom space
		|| (addr[15:13] == 3'b101);                        // cart ram A000-BFFF
	assign sel_wram = (addr[15:14] == 2'b11) && (addr[15:9] != 7'h7F); // C000-FDFF
	assign sel_zp   = (addr[15:7] == 9'h1FF) && (addr != `GB_ADDR_IE);  // FF80-FFFE
	assign sel_p1   = addr == `GB_ADDR_P1;
	assign sel_if   = addr == `GB_ADDR_IF;
	assign sel_sc   = addr == `GB_ADDR_SC;
	assign sel_ie   = addr == `GB_ADDR_IE;
	assign sel_bootreg = addr == `GB_ADDR_BOOT;
	// boot code sees the flag only while the rom is still mapped
	assign sel_fast = sel_bootreg && fast_boot && boot_en;
	// SB falls through to open bus, no decode needed

	// write strobes, same cycle as wr
	assign wram_we = wr && sel_wram;
	assign zp_we   = wr && sel_zp;
	assign ie_wr   = wr && sel_ie;
	assign if_wr   = wr && sel_if;
	assign joy_wr  = wr && sel_p1;
	assign sc_wr   = wr && sel_sc;
	assign boot_wr = wr && sel_bootreg;

	// cartridge port
	assign cart_addr = addr;
	assign cart_di   = wr_data;
	assign cart_rd   = rd && sel_cart;
	assign cart_wr   = wr && sel_cart;

	// ------------------------------------------------------------
	// read select, registered on rd / ack
	// ------------------------------------------------------------
	gb_pkg::data_t   byte_next, rd_byte;
	gb_pkg::rd_src_t src_next, rd_src;

	always_comb begin
		src_next  = gb_pkg::RD_BYTE;
		byte_next = `GB_OPEN_BUS;
		if (irq_ack)
			src_next = gb_pkg::RD_VEC;   // vector registered by irq_ctrl at this edge
		else if (sel_wram)
			src_next = gb_pkg::RD_WRAM;
		else if (sel_zp)
			src_next = gb_pkg::RD_ZP;
		else if (sel_fast)
			byte_next = `GB_FAST_BOOT_FLAG;
		else if (sel_if)
			byte_next = {3'b111, if_val};   // unused bits read high
		else if (sel_ie)
			byte_next = {3'b000, ie_val};
		else if (sel_p1)
			byte_next = joy_val;
		else if (sel_sc)
			byte_next = sc_val;
		else if (sel_boot)
			byte_next = boot_data;
		else if (sel_cart)
			byte_next = cart_do;   // cart answers combinationally in the rd cycle
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			rd_src <= gb_pkg::RD_BYTE;
		end else if (rd || irq_ack) begin
			rd_src <= src_next;
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (rd || irq_ack)
			rd_byte <= byte_next;
	end

	// ram q already holds the word addressed in the rd cycle
	always_comb begin
		case (rd_src)
			gb_pkg::RD_WRAM: rd_data = wram_q;
			gb_pkg::RD_ZP:   rd_data = zp_q;
			gb_pkg::RD_VEC:  rd_data = irq_vec;
			default:         rd_data = rd_byte;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/gb_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gb_defs.svh"

module gb_bus_top (
	input  wire             clk_cpu,
	input  wire             reset,
	input  wire             fast_boot,
	input  gb_pkg::joy_t    joystick,
	input  wire [2:0]       ext_irq,    // vblank, lcd, timer pulses
	input  gb_pkg::addr_t   addr,
	input  gb_pkg::data_t   wr_data,
	input  wire             rd,
	input  wire             wr,
	input  wire             irq_ack,
	input  gb_pkg::data_t   cart_do,
	output gb_pkg::data_t   rd_data,
	output wire             irq_n,
	output gb_pkg::addr_t   cart_addr,
	output gb_pkg::data_t   cart_di,
	output wire             cart_rd,
	output wire             cart_wr
);

	gb_pkg::data_t wram_q, zp_q, boot_data, irq_vec, joy_val, sc_val;
	gb_pkg::irq_t  ie_val, if_val;
	logic          wram_we, zp_we, ie_wr, if_wr, joy_wr, sc_wr, boot_wr;
	logic          boot_en;
	logic          ser_irq, joy_irq;

	mem_map u_mem_map (
		.clk_cpu(clk_cpu), .reset(reset), .addr(addr), .wr_data(wr_data),
		.rd(rd), .wr(wr), .irq_ack(irq_ack), .fast_boot(fast_boot),
		.cart_do(cart_do), .boot_en(boot_en), .boot_data(boot_data),
		.wram_q(wram_q), .zp_q(zp_q), .ie_val(ie_val), .if_val(if_val),
		.irq_vec(irq_vec), .joy_val(joy_val), .sc_val(sc_val),
		.rd_data(rd_data), .cart_addr(cart_addr), .cart_di(cart_di),
		.cart_rd(cart_rd), .cart_wr(cart_wr), .wram_we(wram_we), .zp_we(zp_we),
		.ie_wr(ie_wr), .if_wr(if_wr), .joy_wr(joy_wr), .sc_wr(sc_wr),
		.boot_wr(boot_wr)
	);

	// work ram, E000-FDFF mirror falls out of the low 13 bits
	spram #(.addr_width(`GB_WRAM_AW)) wram (
		.clk_cpu(clk_cpu), .address(addr[`GB_WRAM_AW-1:0]), .we(wram_we),
		.data(wr_data), .q(wram_q)
	);

	spram #(.addr_width(`GB_ZP_AW)) zpram (
		.clk_cpu(clk_cpu), .address(addr[`GB_ZP_AW-1:0]), .we(zp_we),
		.data(wr_data), .q(zp_q)
	);

	boot_rom u_boot_rom (
		.clk_cpu(clk_cpu), .reset(reset), .addr(addr[`GB_BOOT_AW-1:0]),
		.boot_wr(boot_wr), .wr_data(wr_data), .boot_en(boot_en),
		.boot_data(boot_data)
	);

	irq_ctrl u_irq_ctrl (
		.clk_cpu(clk_cpu), .reset(reset),
		.irq_src({joy_irq, ser_irq, ext_irq}),   // bit 0 = vblank
		.ie_wr(ie_wr), .if_wr(if_wr), .wr_data(wr_data), .irq_ack(irq_ack),
		.ie_val(ie_val), .if_val(if_val), .irq_vec(irq_vec), .irq_n(irq_n)
	);

	joypad u_joypad (
		.clk_cpu(clk_cpu), .reset(reset), .joystick(joystick), .joy_wr(joy_wr),
		.wr_data(wr_data), .joy_val(joy_val), .joy_irq(joy_irq)
	);

	serial_port u_serial_port (
		.clk_cpu(clk_cpu), .reset(reset), .sc_wr(sc_wr), .wr_data(wr_data),
		.sc_val(sc_val), .ser_irq(ser_irq)
	);

endmodule

`default_nettype wire

// ==== sim/gb_bus_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module gb_bus_checker (
	input wire          clk_cpu,
	input wire          reset,
	input wire          rd,
	input wire          wr,
	input wire          irq_ack,
	input wire          cart_wr,
	input gb_pkg::irq_t ie_val,
	input gb_pkg::irq_t if_val,
	input wire          irq_n
);

	int assert_fails = 0;   // failed assertion count

	// ------------------------------------------------------------
	// cpu bus strobes
	// ------------------------------------------------------------
	a_one_strobe: assert property (@(posedge clk_cpu) disable iff (reset)
		$onehot0({rd, wr, irq_ack}))
		else begin
			$error("rd, wr and irq_ack overlap");
			assert_fails = assert_fails + 1;
		end

	a_cart_wr: assert property (@(posedge clk_cpu) disable iff (reset) cart_wr |-> wr)
		else begin
			$error("cart_wr without a cpu write");
			assert_fails = assert_fails + 1;
		end

	// irq line follows pending & enabled
	a_irq_line: assert property (@(posedge clk_cpu) disable iff (reset)
		irq_n == ~|(ie_val & if_val))
		else begin
			$error("irq_n does not match IE & IF");
			assert_fails = assert_fails + 1;
		end

	a_irq_reset: assert property (@(posedge clk_cpu) reset |=> irq_n)
		else begin
			$error("irq_n low right after reset");
			assert_fails = assert_fails + 1;
		end

endmodule

bind gb_bus_top gb_bus_checker chk (
	.clk_cpu(clk_cpu), .reset(reset), .rd(rd), .wr(wr), .irq_ack(irq_ack),
	.cart_wr(cart_wr), .ie_val(ie_val), .if_val(if_val), .irq_n(irq_n)
);

`default_nettype wire

// ==== sim/gb_bus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gb_defs.svh"

module gb_bus_tb;

	logic          clk_cpu;
	logic          reset;
	logic          fast_boot;
	gb_pkg::joy_t  joystick;
	logic [2:0]    ext_irq;
	gb_pkg::addr_t addr;
	gb_pkg::data_t wr_data;
	logic          rd;
	logic          wr;
	logic          irq_ack;
	gb_pkg::data_t cart_do;
	gb_pkg::data_t rd_data;
	logic          irq_n;
	gb_pkg::addr_t cart_addr;
	gb_pkg::data_t cart_di;
	logic          cart_rd;
	logic          cart_wr;

	integer        seed = 32'h9856;
	int            cycle = 0;             // free running cycle count
	gb_pkg::data_t boot_image [0:255];    // reference copy of the boot rom

	// cartridge model, 64k image, read strobe count and a record of the last write
	gb_pkg::data_t cart_mem [0:65535];
	gb_pkg::addr_t last_cart_addr;
	gb_pkg::data_t last_cart_data;
	int            cart_writes = 0;
	int            cart_reads = 0;

	gb_bus_top UUT (
		.clk_cpu(clk_cpu), .reset(reset), .fast_boot(fast_boot), .joystick(joystick),
		.ext_irq(ext_irq), .addr(addr), .wr_data(wr_data), .rd(rd), .wr(wr),
		.irq_ack(irq_ack), .cart_do(cart_do), .rd_data(rd_data), .irq_n(irq_n),
		.cart_addr(cart_addr), .cart_di(cart_di), .cart_rd(cart_rd), .cart_wr(cart_wr)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #20 clk_cpu = ~clk_cpu;   // 40 ns period
	end

	always @(posedge clk_cpu) cycle <= cycle + 1;

	// fill byte, every address bit counts
	function automatic gb_pkg::data_t cart_pattern(input gb_pkg::addr_t a);
		return a[15:8] ^ {a[6:0], a[7]} ^ 8'h5A;
	endfunction

	assign cart_do = cart_mem[cart_addr];   // answers inside the rd cycle

	always @(posedge clk_cpu) begin
		if (cart_rd)
			cart_reads <= cart_reads + 1;
		if (cart_wr) begin
			cart_mem[cart_addr] <= cart_di;
			last_cart_addr      <= cart_addr;
			last_cart_data      <= cart_di;
			cart_writes         <= cart_writes + 1;
		end
	end

	// P1 value: 11, select bits, then low nibble pulled down by enabled groups
	function automatic gb_pkg::data_t joy_expect(input logic [1:0] sel,
		input gb_pkg::joy_t keys);
		logic [3:0] lines;
		lines = 4'hF;
		if (!sel[0])
			lines = lines & ~keys[3:0];   // directions
		if (!sel[1])
			lines = lines & ~keys[7:4];   // buttons
		return {2'b11, sel, lines};
	endfunction

	// ------------------------------------------------------------
	// error reporting and bus tasks
	// ------------------------------------------------------------
	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input gb_pkg::data_t expected,
		input gb_pkg::data_t actual);
		if (actual !== expected)
			stop_with_error($sformatf("ERR %s: expected %h, got %h", name, expected, actual));
	endtask

	task automatic write_byte(input gb_pkg::addr_t a, input gb_pkg::data_t d);
		@(posedge clk_cpu);
		addr    <= a;
		wr_data <= d;
		wr      <= 1'b1;
		@(posedge clk_cpu);   // write lands here
		wr <= 1'b0;
	endtask

	task automatic read_byte(input gb_pkg::addr_t a, output gb_pkg::data_t d);
		@(posedge clk_cpu);
		addr <= a;
		rd   <= 1'b1;
		@(posedge clk_cpu);
		rd <= 1'b0;
		@(negedge clk_cpu);   // data cycle follows the strobe
		d = rd_data;
	endtask

	task automatic ack_irq(output gb_pkg::data_t vec);
		@(posedge clk_cpu);
		irq_ack <= 1'b1;
		@(posedge clk_cpu);
		irq_ack <= 1'b0;
		@(negedge clk_cpu);
		vec = rd_data;
	endtask

	task automatic wait_irq_level(input logic level, input int limit);
		int n;
		n = 0;
		@(negedge clk_cpu);
		while (irq_n !== level) begin
			if (n == limit)
				stop_with_error($sformatf("irq_n stuck, not %0b after %0d cycles", level, limit));
			n++;
			@(negedge clk_cpu);
		end
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic ram_readback();
		gb_pkg::addr_t a [16];
		gb_pkg::data_t d [16];
		gb_pkg::data_t v;
		integer        r;
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			// 0..7 work ram, 8..15 zero page
			a[i] = (i < 8) ? 16'hC000 + 16'(i) * 16'h0403 : 16'hFF80 + 16'(i - 8) * 16'h000F;
			d[i] = r[7:0];
			write_byte(a[i], d[i]);
		end
		for (int i = 0; i < 16; i++) begin
			read_byte(a[i], v);
			check_value($sformatf("rd_data @%h", a[i]), d[i], v);
		end
		r = $random(seed);
		write_byte(16'hE123, r[7:0]);   // echo region
		read_byte(16'hC123, v);
		check_value("rd_data @C123 mirror", r[7:0], v);
	endtask

	task automatic boot_and_cart_reads();
		gb_pkg::data_t v;
		int            n;
		n = cart_reads;
		for (int i = 0; i < 256; i++) begin
			read_byte(16'(i), v);
			check_value($sformatf("rd_data @%04h boot", i), boot_image[i], v);
		end
		if (cart_reads != n)
			stop_with_error("cartridge read strobe seen during boot rom reads");
		read_byte(16'h0100, v);
		check_value("rd_data @0100", cart_pattern(16'h0100), v);
		read_byte(16'hA000, v);
		check_value("rd_data @A000", cart_pattern(16'hA000), v);
		if (cart_reads != n + 2)
			stop_with_error("cartridge read strobe missing for 0100 or A000");
		read_byte(`GB_ADDR_BOOT, v);
		check_value("rd_data @FF50", `GB_FAST_BOOT_FLAG, v);
		write_byte(`GB_ADDR_BOOT, 8'h01);   // unmap the boot rom
		read_byte(16'h0000, v);
		check_value("rd_data @0000 unmapped", cart_pattern(16'h0000), v);
		read_byte(`GB_ADDR_BOOT, v);
		check_value("rd_data @FF50 unmapped", `GB_OPEN_BUS, v);
	endtask

	task automatic open_bus_and_cart_write();
		gb_pkg::addr_t open_addr [3] = '{16'h8000, 16'hFF40, `GB_ADDR_SB};
		gb_pkg::data_t v;
		gb_pkg::data_t d;
		integer        r;
		int            n;
		r = $random(seed);
		d = r[7:0];
		n = cart_writes;
		write_byte(16'h2000, d);
		@(negedge clk_cpu);
		if (cart_writes != n + 1)
			stop_with_error("cartridge saw no write cycle for address 2000");
		check_value("cart_addr[15:8]", 8'h20, last_cart_addr[15:8]);
		check_value("cart_addr[7:0]", 8'h00, last_cart_addr[7:0]);
		check_value("cart_di", d, last_cart_data);
		foreach (open_addr[i]) begin
			read_byte(open_addr[i], v);
			check_value($sformatf("rd_data @%h", open_addr[i]), `GB_OPEN_BUS, v);
		end
	endtask

	task automatic irq_priority();
		gb_pkg::data_t v;
		gb_pkg::data_t exp_vec [3] = '{8'h40, 8'h48, 8'h50};   // vblank, lcd, timer
		write_byte(`GB_ADDR_IE, 8'h1F);
		@(posedge clk_cpu);
		ext_irq <= 3'b111;   // vblank, lcd, timer together
		@(posedge clk_cpu);
		ext_irq <= 3'b000;
		wait_irq_level(1'b0, 10);
		for (int i = 0; i < 3; i++) begin
			ack_irq(v);
			check_value($sformatf("rd_data ack %0d", i), exp_vec[i], v);
		end
		ack_irq(v);   // nothing left
		check_value("rd_data ack empty", `GB_IRQ_VEC_NONE, v);
		check_value("irq_n", 8'h01, 8'(irq_n));
		read_byte(`GB_ADDR_IF, v);
		check_value("rd_data @FF0F", 8'hE0, v);
	endtask

	task automatic joypad_press();
		gb_pkg::data_t v;
		int            n;
		write_byte(`GB_ADDR_IF, 8'h00);
		write_byte(`GB_ADDR_P1, 8'h20);   // directions only
		@(posedge clk_cpu);
		joystick <= 8'h09;   // right + down
		n = 0;
		read_byte(`GB_ADDR_IF, v);
		while (!v[4]) begin
			if (n == 10)
				stop_with_error("joypad press never set IF bit 4");
			n++;
			read_byte(`GB_ADDR_IF, v);
		end
		read_byte(`GB_ADDR_P1, v);
		check_value("rd_data @FF00", joy_expect(2'b10, 8'h09), v);
	endtask

	task automatic serial_transfer();
		gb_pkg::data_t v;
		int            start;
		write_byte(`GB_ADDR_IF, 8'h00);
		write_byte(`GB_ADDR_SC, 8'h81);   // start, internal clock
		read_byte(`GB_ADDR_SC, v);
		check_value("rd_data @FF02", 8'hFF, v);
		start = cycle;
		read_byte(`GB_ADDR_SC, v);
		while (v[7]) begin
			if (cycle - start > 6000)
				stop_with_error("serial transfer still busy after 6000 cycles");
			read_byte(`GB_ADDR_SC, v);
		end
		check_value("rd_data @FF02 done", 8'h7F, v);
		read_byte(`GB_ADDR_IF, v);
		check_value("rd_data @FF0F", 8'hE8, v);   // only the serial flag
		read_byte(`GB_ADDR_SB, v);
		check_value("rd_data @FF01", `GB_OPEN_BUS, v);
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		$readmemh("verilog/boot_rom.hex", boot_image);
		for (int i = 0; i < 65536; i++)
			cart_mem[i] = cart_pattern(16'(i));
		reset     = 1'b1;
		fast_boot = 1'b1;
		joystick  = '0;
		ext_irq   = '0;
		addr      = '0;
		wr_data   = '0;
		rd        = 1'b0;
		wr        = 1'b0;
		irq_ack   = 1'b0;
		repeat (2) @(posedge clk_cpu);
		reset <= 1'b0;

		ram_readback();
		boot_and_cart_reads();
		open_bus_and_cart_write();
		irq_priority();
		joypad_press();
		serial_transfer();

		if (UUT.chk.assert_fails == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			stop_with_error("bus checker assertions fired");
		end
	end

endmodule

`default_nettype wire

// ==== gb_bus.f ====
+incdir+verilog
verilog/gb_pkg.sv
verilog/spram.sv
verilog/boot_rom.sv
verilog/irq_ctrl.sv
verilog/joypad.sv
verilog/serial_port.sv
verilog/mem_map.sv
verilog/gb_bus_top.sv
sim/gb_bus_checker.sv
sim/gb_bus_tb.sv

// ==== Makefile ====
# Verilator build and run for the bus fabric testbench

VERILATOR ?= verilator
TOP       ?= gb_bus_tb
FILELIST  ?= gb_bus.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verilog/boot_rom.hex ====
// boot rom image, one byte per column, 16 bytes per line, line n starts at address n*16
A5 A4 A7 A6 A1 A0 A3 A2 AD AC AF AE A9 A8 AB AA
B5 B4 B7 B6 B1 B0 B3 B2 BD BC BF BE B9 B8 BB BA
85 84 87 86 81 80 83 82 8D 8C 8F 8E 89 88 8B 8A
95 94 97 96 91 90 93 92 9D 9C 9F 9E 99 98 9B 9A
E5 E4 E7 E6 E1 E0 E3 E2 ED EC EF EE E9 E8 EB EA
F5 F4 F7 F6 F1 F0 F3 F2 FD FC FF FE F9 F8 FB FA
C5 C4 C7 C6 C1 C0 C3 C2 CD CC CF CE C9 C8 CB CA
D5 D4 D7 D6 D1 D0 D3 D2 DD DC DF DE D9 D8 DB DA
25 24 27 26 21 20 23 22 2D 2C 2F 2E 29 28 2B 2A
35 34 37 36 31 30 33 32 3D 3C 3F 3E 39 38 3B 3A
05 04 07 06 01 00 03 02 0D 0C 0F 0E 09 08 0B 0A
15 14 17 16 11 10 13 12 1D 1C 1F 1E 19 18 1B 1A
65 64 67 66 61 60 63 62 6D 6C 6F 6E 69 68 6B 6A
75 74 77 76 71 70 73 72 7D 7C 7F 7E 79 78 7B 7A
45 44 47 46 41 40 43 42 4D 4C 4F 4E 49 48 4B 4A
55 54 57 56 51 50 53 52 5D 5C 5F 5E 59 58 5B 5A
